// ==== all.f ====
+incdir+include
rtl/idc_pkg.sv
rtl/idc_beat_if.sv
rtl/idc_letter_map.sv
rtl/idc_seq_ctrl.sv
rtl/idc_mod10_acc.sv
rtl/idc_top.sv
tb/tb_idc.sv

// ==== tb/tb_idc.sv ====
// Self-checking random testbench for the identity number checker, run as the simulation top
`timescale 1ns/1ps
`include "idc_defines.svh"

module tb_idc
    import idc_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_LEGAL    = 200;
    localparam int NUM_CORRUPT  = 200;
    localparam int NUM_RANDOM   = 300;
    localparam int NUM_B2B      = 20;
    localparam int IDLE_CYCLES  = 2;
    localparam int NUM_LETTERS  = 26;

    // Every full number plus the aborted one
    localparam int NUM_TOTAL = NUM_LEGAL + NUM_CORRUPT + NUM_RANDOM + NUM_B2B + 2;
    localparam int WATCHDOG_CYCLES =
        RESET_CYCLES + NUM_TOTAL * (`IDC_BEATS + IDLE_CYCLES + 1) + 100;

    logic clk;
    logic rst_n;
    logic in_valid;
    id_t  in_id;
    logic out_valid;
    logic out_legal_id;

    integer seed;
    int     errors;
    int     tests_passed;
    int     tests_failed;
    bit     pulse_expected;
    bit     hold_check_on;
    logic   last_legal;

    // Number currently being driven
    int     cur_letter;
    int     cur_digits [0:`IDC_NUM_DIGITS-1];
    int     cur_check;

    idc_top u_idc_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_id        (in_id),
        .out_valid    (out_valid),
        .out_legal_id (out_legal_id)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    // Letters in code order from A at 10 to O at 35
    function automatic int letter_code(input int letter);
        string order;
        order = "ABCDEFGHJKLMNPQRSTUVXYWZIO";
        for (int i = 0; i < NUM_LETTERS; i++) begin
            if (order[i] == 65 + letter) begin
                return 10 + i;
            end
        end
        return 0;
    endfunction

    task automatic model_sum(output int sum);
        int code;
        code = letter_code(cur_letter);
        sum = code / 10 + 9 * (code % 10);
        for (int i = 1; i <= `IDC_NUM_DIGITS; i++) begin
            sum = sum + cur_digits[i-1] * (9 - i);
        end
        sum = sum % `IDC_MOD;
    endtask

    task automatic model_legal(output bit legal);
        int sum;
        model_sum(sum);
        legal = ((sum + cur_check) % `IDC_MOD) == 0;
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    task automatic random_digits();
        for (int i = 0; i < `IDC_NUM_DIGITS; i++) begin
            cur_digits[i] = rand_below(`IDC_MOD);
        end
    endtask

    // Check digit chosen so the total is 0 mod 10
    task automatic build_legal(input int letter);
        int sum;
        cur_letter = letter;
        random_digits();
        model_sum(sum);
        cur_check = (`IDC_MOD - sum) % `IDC_MOD;
    endtask

    // Starts right after a rising edge and ends on the edge sampling the last beat
    task automatic drive_number(input int n_beats);
        for (int b = 0; b < n_beats; b++) begin
            if (b > 0) begin
                @(posedge clk);
            end
            in_valid <= 1'b1;
            if (b == 0) begin
                in_id <= id_t'(cur_letter);
            end else if (b <= `IDC_NUM_DIGITS) begin
                in_id <= id_t'(cur_digits[b-1]);
            end else begin
                in_id <= id_t'(cur_check);
            end
        end
        @(posedge clk);
        if (n_beats == `IDC_BEATS) begin
            pulse_expected = 1'b1;
        end
        in_valid <= 1'b0;
        in_id    <= '0;
    endtask

    task automatic run_number(input bit expected, input int idle);
        drive_number(`IDC_BEATS);
        @(negedge clk);
        if (out_valid !== 1'b1) begin
            $display("No out_valid pulse at time %0t after the check digit", $time);
            errors = errors + 1;
        end
        if (out_legal_id !== expected) begin
            $display("ERROR at %0t: letter %0d check %0d, out_legal_id expected %0d, got %0d",
                     $time, cur_letter, cur_check, expected, out_legal_id);
            errors = errors + 1;
        end
        last_legal = expected;
        @(posedge clk);
        pulse_expected = 1'b0;
        repeat (idle - 1) @(posedge clk);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed = tests_passed + 1;
            $display("Test %s: passed", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("Test %s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // ------------------------------------------------------------
    // Output monitor
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n && hold_check_on) begin
            if (out_valid && !pulse_expected) begin
                $display("Unexpected out_valid pulse at time %0t with no number completing",
                         $time);
                errors = errors + 1;
            end
            if (!out_valid && (out_legal_id !== last_legal)) begin
                $display("ERROR at %0t: out_legal_id moved between results, expected %0d, got %0d",
                         $time, last_legal, out_legal_id);
                errors = errors + 1;
            end
        end
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        int start_errors;
        bit legal;
        int good_check;

        seed           = 72;
        errors         = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        pulse_expected = 1'b0;
        hold_check_on  = 1'b0;
        last_legal     = 1'b0;
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        in_id          = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        start_errors = errors;
        @(negedge clk);
        if (out_valid !== 1'b0) begin
            $display("ERROR at %0t: out_valid after reset expected 0, got %0d",
                     $time, out_valid);
            errors = errors + 1;
        end
        if (out_legal_id !== 1'b0) begin
            $display("ERROR at %0t: out_legal_id after reset expected 0, got %0d",
                     $time, out_legal_id);
            errors = errors + 1;
        end
        @(posedge clk);
        hold_check_on = 1'b1;
        finish_test("output after reset", start_errors);

        // Letters cycle so each one appears
        start_errors = errors;
        for (int i = 0; i < NUM_LEGAL; i++) begin
            build_legal(i % NUM_LETTERS);
            run_number(1'b1, IDLE_CYCLES);
        end
        finish_test("legal numbers", start_errors);

        start_errors = errors;
        for (int i = 0; i < NUM_CORRUPT; i++) begin
            build_legal(rand_below(NUM_LETTERS));
            good_check = cur_check;
            cur_check  = (good_check + 1 + rand_below(`IDC_MOD - 1)) % `IDC_MOD;
            run_number(1'b0, IDLE_CYCLES);
        end
        finish_test("corrupted check digit", start_errors);

        start_errors = errors;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            cur_letter = rand_below(NUM_LETTERS);
            random_digits();
            cur_check = rand_below(`IDC_MOD);
            model_legal(legal);
            run_number(legal, IDLE_CYCLES);
        end
        finish_test("fully random numbers", start_errors);

        // Legal and random numbers alternate with one idle cycle between
        start_errors = errors;
        for (int i = 0; i < NUM_B2B; i++) begin
            if (i % 2 == 0) begin
                build_legal(rand_below(NUM_LETTERS));
            end else begin
                cur_letter = rand_below(NUM_LETTERS);
                random_digits();
                cur_check = rand_below(`IDC_MOD);
            end
            model_legal(legal);
            run_number(legal, 1);
        end
        finish_test("back-to-back numbers", start_errors);

        // Five beats and a gap before a full number
        start_errors = errors;
        build_legal(rand_below(NUM_LETTERS));
        drive_number(5);
        repeat (3) @(posedge clk);
        cur_letter = rand_below(NUM_LETTERS);
        random_digits();
        cur_check = rand_below(`IDC_MOD);
        model_legal(legal);
        run_number(legal, IDLE_CYCLES);
        finish_test("aborted number", start_errors);

        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== rtl/idc_top.sv ====
// Top level of the identity number checker, the block to instantiate in a system
`timescale 1ns/1ps

module idc_top
    import idc_pkg::*;
(
    // Clock and reset
    input  logic clk,
    input  logic rst_n,

    // Beat stream, one beat per cycle while in_valid
    input  logic in_valid,
    input  id_t  in_id,

    // Result
    output logic out_valid,
    output logic out_legal_id
);

    // ------------------------------------------------------------
    // Beat commands
    // ------------------------------------------------------------
    idc_beat_if u_beat_if ();

    // ------------------------------------------------------------
    // Sequencer
    // ------------------------------------------------------------
    // Marks letter, body digit and check beats
    idc_seq_ctrl u_seq_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_id    (in_id),
        .beat     (u_beat_if.controller)
    );

    // ------------------------------------------------------------
    // Accumulator
    // ------------------------------------------------------------
    // Running checksum and registered result
    idc_mod10_acc u_mod10_acc (
        .clk          (clk),
        .rst_n        (rst_n),
        .beat         (u_beat_if.accumulator),
        .out_valid    (out_valid),
        .out_legal_id (out_legal_id)
    );

endmodule

// ==== rtl/idc_mod10_acc.sv ====
// Weighted modulo-10 accumulator with the final checksum test and the result registers
`timescale 1ns/1ps
`include "idc_defines.svh"

module idc_mod10_acc
    import idc_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    idc_beat_if.accumulator beat,
    output logic out_valid,
    output logic out_legal_id
);

    // Two residues summed, before folding
    typedef logic [`IDC_DIGIT_W:0] wide_sum_t;

    residue_t                    residue;
    residue_t                    letter_res;
    digit_t                      digit;
    logic [2*`IDC_DIGIT_W-1:0]   product;
    residue_t                    prod_res;
    wide_sum_t                   step_sum;
    wide_sum_t                   check_sum;
    logic                        legal;

    // Fold a sum below 2 * 10 back into 0 to 9
    function automatic residue_t mod10_fold(input wide_sum_t value);
        wide_sum_t folded;
        folded = (value >= wide_sum_t'(`IDC_MOD)) ? value - wide_sum_t'(`IDC_MOD) : value;
        return residue_t'(folded);
    endfunction

    // ------------------------------------------------------------
    // Letter residue
    // ------------------------------------------------------------
    idc_letter_map u_letter_map (
        .letter  (beat.value),
        .residue (letter_res)
    );

    // ------------------------------------------------------------
    // Body digit step
    // ------------------------------------------------------------
    assign digit = beat.value[`IDC_DIGIT_W-1:0];

    // At most 9 * 8
    assign product = digit * beat.weight;

    assign prod_res = residue_t'(product % `IDC_MOD);

    assign step_sum = {1'b0, residue} + {1'b0, prod_res};

    // ------------------------------------------------------------
    // Final check
    // ------------------------------------------------------------
    // Check digit has weight 1
    assign check_sum = {1'b0, residue} + {1'b0, digit};

    assign legal = (mod10_fold(check_sum) == '0);

    // ------------------------------------------------------------
    // Running residue
    // ------------------------------------------------------------
    // Reloaded by every letter
    always_ff @(posedge clk) begin
        if (beat.load_letter) begin
            residue <= letter_res;
        end else if (beat.add_digit) begin
            residue <= mod10_fold(step_sum);
        end
    end

    // ------------------------------------------------------------
    // Result registers
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid    <= 1'b0;
            out_legal_id <= 1'b0;
        end else begin
            // One pulse per completed number
            out_valid <= beat.check;
            if (beat.check) begin
                out_legal_id <= legal;
            end
        end
    end

endmodule

// ==== rtl/idc_seq_ctrl.sv ====
// Beat sequencer that classifies each input beat and supplies the body digit weight
`timescale 1ns/1ps
`include "idc_defines.svh"

module idc_seq_ctrl
    import idc_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  id_t      in_id,
    idc_beat_if.controller beat
);

    // Counter value of the eighth body digit
    localparam logic [`IDC_CNT_W-1:0] LAST_DIGIT = `IDC_CNT_W'(`IDC_NUM_DIGITS - 1);

    idc_state_e               state;
    idc_state_e               state_nxt;
    logic [`IDC_CNT_W-1:0]    digit_cnt;

    // ------------------------------------------------------------
    // Beat classification
    // ------------------------------------------------------------
    always_comb begin
        beat.load_letter = 1'b0;
        beat.add_digit   = 1'b0;
        beat.check       = 1'b0;
        case (state)
            ST_LETTER: beat.load_letter = in_valid;
            ST_DIGITS: beat.add_digit   = in_valid;
            ST_CHECK:  beat.check       = in_valid;
            default: begin
                beat.load_letter = 1'b0;
            end
        endcase
    end

    assign beat.value = in_id;

    // Digit i has weight 9 - i, counter holds i - 1
    assign beat.weight = residue_t'(`IDC_NUM_DIGITS) - residue_t'(digit_cnt);

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ST_LETTER: begin
                if (in_valid) begin
                    state_nxt = ST_DIGITS;
                end
            end
            ST_DIGITS: begin
                // Gap in the stream abandons the number
                if (!in_valid) begin
                    state_nxt = ST_LETTER;
                end else if (digit_cnt == LAST_DIGIT) begin
                    state_nxt = ST_CHECK;
                end
            end
            ST_CHECK: begin
                state_nxt = ST_LETTER;
            end
            default: begin
                state_nxt = ST_LETTER;
            end
        endcase
    end

    // ------------------------------------------------------------
    // State and digit counter
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_LETTER;
            digit_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (beat.load_letter) begin
                digit_cnt <= '0;
            end else if (beat.add_digit) begin
                digit_cnt <= digit_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/idc_letter_map.sv ====
// Letter index to weighted residue table, used by the accumulator on the letter beat
`timescale 1ns/1ps

module idc_letter_map
    import idc_pkg::*;
(
    input  id_t      letter,
    output residue_t residue
);

    // ------------------------------------------------------------
    // Residue of tens + 9 * units for each letter code
    // ------------------------------------------------------------
    always_comb begin
        case (letter)
            // A to H, codes 10 to 17
            6'd0:    residue = 4'd1;
            6'd1:    residue = 4'd0;
            6'd2:    residue = 4'd9;
            6'd3:    residue = 4'd8;
            6'd4:    residue = 4'd7;
            6'd5:    residue = 4'd6;
            6'd6:    residue = 4'd5;
            6'd7:    residue = 4'd4;

            // I is 34, out of order
            6'd8:    residue = 4'd9;

            // J, K are 18, 19
            6'd9:    residue = 4'd3;
            6'd10:   residue = 4'd2;

            // L to N, codes 20 to 22
            6'd11:   residue = 4'd2;
            6'd12:   residue = 4'd1;
            6'd13:   residue = 4'd0;

            // O is 35
            6'd14:   residue = 4'd8;

            // P to V, codes 23 to 29
            6'd15:   residue = 4'd9;
            6'd16:   residue = 4'd8;
            6'd17:   residue = 4'd7;
            6'd18:   residue = 4'd6;
            6'd19:   residue = 4'd5;
            6'd20:   residue = 4'd4;
            6'd21:   residue = 4'd3;

            // W is 32
            6'd22:   residue = 4'd1;

            // X, Y are 30, 31
            6'd23:   residue = 4'd3;
            6'd24:   residue = 4'd2;

            // Z is 33
            6'd25:   residue = 4'd0;

            // Not a letter
            default: residue = 4'd0;
        endcase
    end

endmodule

// ==== rtl/idc_beat_if.sv ====
// Decoded beat commands passed from the beat sequencer to the accumulator
`timescale 1ns/1ps

interface idc_beat_if
    import idc_pkg::*;
();

    // At most one strobe high per cycle
    logic     load_letter;
    logic     add_digit;
    logic     check;

    // Weight of the current body digit
    residue_t weight;

    // Beat value as received
    id_t      value;

    modport controller (
        output load_letter,
        output add_digit,
        output check,
        output weight,
        output value
    );

    modport accumulator (
        input  load_letter,
        input  add_digit,
        input  check,
        input  weight,
        input  value
    );

endinterface

// ==== rtl/idc_pkg.sv ====
// Shared types of the identity number checker, imported by every RTL file
`include "idc_defines.svh"

package idc_pkg;

    // ------------------------------------------------------------
    // Controller state
    // ------------------------------------------------------------
    // Waiting for letter, taking body digits, taking check digit
    typedef enum logic [1:0] {
        ST_LETTER = 2'd0,
        ST_DIGITS = 2'd1,
        ST_CHECK  = 2'd2
    } idc_state_e;

    // ------------------------------------------------------------
    // Data types
    // ------------------------------------------------------------
    // Decimal digit 0 to 9
    typedef logic [`IDC_DIGIT_W-1:0] digit_t;

    // Value modulo 10
    typedef logic [`IDC_DIGIT_W-1:0] residue_t;

    // Raw input beat
    typedef logic [`IDC_ID_W-1:0] id_t;

endpackage

// ==== include/idc_defines.svh ====
// Widths and counts of the identity number checker, included by the RTL and the testbench
`ifndef IDC_DEFINES_SVH
`define IDC_DEFINES_SVH

// ------------------------------------------------------------
// Beat and digit widths
// ------------------------------------------------------------
`define IDC_ID_W       6
`define IDC_DIGIT_W    4

// ------------------------------------------------------------
// Number format
// ------------------------------------------------------------
// Letter, eight body digits, check digit
`define IDC_BEATS      10
`define IDC_NUM_DIGITS (`IDC_BEATS - 2)

// Counts body digits 0 to 7
`define IDC_CNT_W      3

// Checksum base
`define IDC_MOD        10

`endif
